// ==== cart_loader.f ====
verilog/cart_loader_pkg.sv
verilog/load_bus_if.sv
verilog/load_decode.sv
verilog/rom_writer.sv
verilog/cheat_assembler.sv
verilog/config_regs.sv
verilog/cart_loader.sv
verif/cart_loader_props.sv
verif/cart_loader_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the cartridge loader testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module cart_loader_tb -f cart_loader.f -o cart_loader_sim

output=$(./obj_dir/cart_loader_sim 2>&1) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qxF '=== PASS ==='; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi

// ==== verif/cart_loader_props.sv ====
//====================================================================
// Concurrent checks on the ROM handshake and the cheat strobe
// Bound into the ROM writer and the cheat assembler by the testbench.
//====================================================================

`timescale 1ns/100ps

module cart_loader_props (
	input logic clk_sys,
	input logic RESET,
	input logic cart_wr,
	input logic ioctl_wait,
	input logic rom_req,
	input logic rom_ack,
	input logic code_valid
);

	// Host holds off while a write is outstanding
	host_holds_off: assert property (@(posedge clk_sys) disable iff (RESET)
		cart_wr |-> !ioctl_wait)
		else $error("cart write arrived while ioctl_wait was high");

	req_flips_when_idle: assert property (@(posedge clk_sys) disable iff (RESET)
		rom_req != $past(rom_req) |-> $past(rom_req == rom_ack))
		else $error("rom_req flipped while a write was outstanding");

	valid_one_cycle: assert property (@(posedge clk_sys) disable iff (RESET)
		code_valid |=> !code_valid)
		else $error("code_valid stayed high for two cycles");

endmodule

// ==== verif/cart_loader_tb.sv ====
//====================================================================
// Directed testbench for the cartridge loading unit
// A ROM memory model acknowledges each write after a random delay.
// Each test task drives the host port and checks the DUT response.
//====================================================================

`timescale 1ns/100ps

module cart_loader_tb;

	localparam int ROM_ADDR_W = 22;
	localparam int ADDR_W     = cart_loader_pkg::IOCTL_ADDR_W;
	localparam int TIMEOUT    = 100;

	logic                          clk_sys;
	logic                          RESET;
	logic                          ioctl_download;
	cart_loader_pkg::ioctl_index_t ioctl_index;
	logic                          ioctl_wr;
	logic [ADDR_W-1:0]             ioctl_addr;
	logic [7:0]                    ioctl_dout;
	logic                          ioctl_wait;
	logic [ROM_ADDR_W-1:0]         rom_addr;
	logic [7:0]                    rom_data;
	logic                          rom_req;
	logic                          rom_ack;
	logic [ROM_ADDR_W-1:0]         cart_mask;
	logic [7:0]                    sysmode, dsw_f2, dsw_f3, dsw_e0;
	logic                          is_gg, is_systeme, code_valid;
	logic [31:0]                   code_flags, code_address, code_compare, code_replace;

	int          seed = 32'h163e_8112;
	int          ack_delay;
	int          error_count = 0;
	int          check_count = 0;
	int          valid_count = 0;
	logic        result_printed = 1'b0;
	// Request level expected after the cart writes so far
	logic        req_level = 1'b0;
	logic [7:0]  rom_mem [64];
	logic [7:0]  cart_bytes [40];
	logic [31:0] seen_flags, seen_address, seen_compare, seen_replace;

	cart_loader #(.ROM_ADDR_W(ROM_ADDR_W)) cart_loader_i (.*);

	// Handshake rules in the ROM writer, strobe rule in the cheat assembler
	bind rom_writer cart_loader_props handshake_props_i (
		.clk_sys    (clk_sys),
		.RESET      (RESET),
		.cart_wr    (cart_wr),
		.ioctl_wait (ioctl_wait),
		.rom_req    (rom_req),
		.rom_ack    (rom_ack),
		.code_valid (1'b0)
	);

	bind cheat_assembler cart_loader_props strobe_props_i (
		.clk_sys    (clk_sys),
		.RESET      (RESET),
		.cart_wr    (1'b0),
		.ioctl_wait (1'b0),
		.rom_req    (1'b0),
		.rom_ack    (1'b0),
		.code_valid (code_valid)
	);

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	//==================================================================
	// ROM memory model
	//==================================================================

	// Responds 2 ns after each edge, between host drive and next edge
	initial begin
		rom_ack   = 1'b0;
		ack_delay = 0;
		for (int i = 0; i < 64; i++)
			rom_mem[i] = 8'(~i);
		forever begin
			@(posedge clk_sys);
			#2;
			if (RESET) begin
				rom_ack   = 1'b0;
				ack_delay = 0;
			end else if (rom_req != rom_ack) begin
				if (ack_delay == 0) begin
					ack_delay = 1 + int'($unsigned($random(seed)) % 6);
				end else begin
					ack_delay--;
					if (ack_delay == 0) begin
						if (rom_addr < ROM_ADDR_W'(64))
							rom_mem[rom_addr[5:0]] = rom_data;
						rom_ack = rom_req;
					end
				end
			end
		end
	end

	// Counts strobes and keeps the record seen with each one
	always @(negedge clk_sys) begin
		if (code_valid) begin
			valid_count++;
			seen_flags   = code_flags;
			seen_address = code_address;
			seen_compare = code_compare;
			seen_replace = code_replace;
		end
	end

	//==================================================================
	// Compare tasks
	//==================================================================

	task automatic check_bit(input string name, input logic expected, input logic actual);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("Fail at %0t: %s expected %b, got %b", $time, name, expected, actual);
		end
	endtask

	task automatic check_byte(input string name, input logic [7:0] expected,
		input logic [7:0] actual);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("Fail at %0t: %s expected %h, got %h", $time, name, expected, actual);
		end
	endtask

	task automatic check_rom_addr(input string name, input logic [ROM_ADDR_W-1:0] expected,
		input logic [ROM_ADDR_W-1:0] actual);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("Fail at %0t: %s expected %h, got %h", $time, name, expected, actual);
		end
	endtask

	task automatic check_word(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("Fail at %0t: %s expected %h, got %h", $time, name, expected, actual);
		end
	endtask

	//==================================================================
	// Host side helpers
	//==================================================================

	task automatic next_cycle();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic abort_on_timeout(input string what);
		$display("Timeout at %0t while waiting for %s", $time, what);
		result_printed = 1'b1;
		$display("=== FAIL ===");
		$finish;
	endtask

	task automatic wait_for_wait(input logic level);
		int cycles;
		cycles = 0;
		while (ioctl_wait !== level) begin
			if (cycles == TIMEOUT)
				abort_on_timeout($sformatf("ioctl_wait to become %b", level));
			next_cycle();
			cycles++;
		end
	endtask

	task automatic host_write(input logic [ADDR_W-1:0] addr, input logic [7:0] data);
		wait_for_wait(1'b0);
		ioctl_addr = addr;
		ioctl_dout = data;
		ioctl_wr   = 1'b1;
		next_cycle();
		ioctl_wr   = 1'b0;
	endtask

	// Cart byte, with wait held until memory has acknowledged
	task automatic cart_write(input logic [ADDR_W-1:0] addr, input logic [7:0] data);
		host_write(addr, data);
		wait_for_wait(1'b1);
		// One request flip per cart byte, ack still behind
		req_level = ~req_level;
		check_bit("rom_req", req_level, rom_req);
		check_bit("rom_ack", ~req_level, rom_ack);
		wait_for_wait(1'b0);
		check_bit("rom_ack", req_level, rom_ack);
	endtask

	task automatic load_cart(input cart_loader_pkg::ioctl_index_t index, input int count);
		ioctl_index    = index;
		ioctl_download = 1'b1;
		next_cycle();
		next_cycle();
		for (int i = 0; i < count; i++)
			cart_write(ADDR_W'(i), cart_bytes[i]);
		ioctl_download = 1'b0;
		next_cycle();
	endtask

	// OR of every address after address 0
	function automatic logic [ROM_ADDR_W-1:0] expected_mask(input int count);
		logic [ROM_ADDR_W-1:0] mask;
		mask = '0;
		for (int i = 1; i < count; i++)
			mask = mask | ROM_ADDR_W'(i);
		return mask;
	endfunction

	task automatic report_test(input string name, input int errors_before);
		$display("Test %s done, %0d error(s)", name, error_count - errors_before);
	endtask

	//==================================================================
	// Directed tests
	//==================================================================

	task automatic test_reset();
		int errors_before;
		errors_before = error_count;
		check_bit("ioctl_wait", 1'b0, ioctl_wait);
		check_bit("rom_req", 1'b0, rom_req);
		check_bit("code_valid", 1'b0, code_valid);
		check_rom_addr("cart_mask", '0, cart_mask);
		check_rom_addr("rom_addr", '0, rom_addr);
		check_byte("sysmode", 8'h00, sysmode);
		check_byte("dsw_f2", 8'h00, dsw_f2);
		check_byte("dsw_f3", 8'h00, dsw_f3);
		check_byte("dsw_e0", 8'h00, dsw_e0);
		check_bit("is_gg", 1'b0, is_gg);
		check_bit("is_systeme", 1'b0, is_systeme);
		report_test("reset state", errors_before);
	endtask

	task automatic test_sms_download();
		int errors_before;
		errors_before = error_count;
		for (int i = 0; i < 40; i++)
			cart_bytes[i] = 8'(i * 37 + 11);
		load_cart(cart_loader_pkg::IDX_SMS, 40);
		for (int i = 0; i < 40; i++)
			check_byte($sformatf("rom_mem[%0d]", i), cart_bytes[i], rom_mem[i]);
		check_rom_addr("rom_addr", ROM_ADDR_W'(40), rom_addr);
		check_rom_addr("cart_mask", expected_mask(40), cart_mask);
		check_bit("is_gg", 1'b0, is_gg);
		report_test("sms download", errors_before);
	endtask

	task automatic test_gg_flag();
		int errors_before;
		errors_before = error_count;
		for (int i = 0; i < 6; i++)
			cart_bytes[i] = 8'(i * 53 + 200);
		load_cart(cart_loader_pkg::IDX_GG, 6);
		for (int i = 0; i < 6; i++)
			check_byte($sformatf("rom_mem[%0d]", i), cart_bytes[i], rom_mem[i]);
		check_rom_addr("cart_mask", expected_mask(6), cart_mask);
		check_bit("is_gg", 1'b1, is_gg);
		load_cart(cart_loader_pkg::IDX_SMS, 3);
		check_rom_addr("cart_mask", expected_mask(3), cart_mask);
		check_bit("is_gg", 1'b0, is_gg);
		report_test("gg flag and mask", errors_before);
	endtask

	task automatic test_config();
		int errors_before;
		errors_before = error_count;
		ioctl_index    = cart_loader_pkg::IDX_SYSMODE;
		ioctl_download = 1'b1;
		host_write(ADDR_W'(0), 8'h5a);
		// Mode bytes past address 0 are ignored
		host_write(ADDR_W'(1), 8'hc3);
		ioctl_index = cart_loader_pkg::IDX_DSW;
		host_write(ADDR_W'(0), 8'h11);
		host_write(ADDR_W'(1), 8'h22);
		host_write(ADDR_W'(2), 8'h33);
		host_write(ADDR_W'(3), 8'h44);
		// Low bits alias the first DIP byte
		host_write(ADDR_W'(4), 8'h55);
		ioctl_download = 1'b0;
		next_cycle();
		check_byte("sysmode", 8'h5a, sysmode);
		check_byte("dsw_f2", 8'h11, dsw_f2);
		check_byte("dsw_f3", 8'h22, dsw_f3);
		check_byte("dsw_e0", 8'h33, dsw_e0);
		check_bit("is_systeme", 1'b1, is_systeme);
		cart_bytes[0] = 8'h99;
		load_cart(cart_loader_pkg::IDX_SMS, 1);
		check_bit("is_systeme", 1'b0, is_systeme);
		report_test("config registers", errors_before);
	endtask

	task automatic test_cheat();
		int errors_before;
		int count_before;
		int cycles;
		logic [7:0] code_bytes [16];
		errors_before = error_count;
		for (int i = 0; i < 16; i++)
			code_bytes[i] = 8'(i * 17 + 3);
		count_before   = valid_count;
		ioctl_index    = cart_loader_pkg::IDX_CHEAT;
		ioctl_download = 1'b1;
		for (int i = 0; i < 16; i++)
			host_write(ADDR_W'(i), code_bytes[i]);
		ioctl_download = 1'b0;
		cycles = 0;
		while (valid_count == count_before) begin
			if (cycles == TIMEOUT)
				abort_on_timeout("code_valid");
			next_cycle();
			cycles++;
		end
		repeat (4) next_cycle();
		check_bit("single code_valid pulse", 1'b1, valid_count == count_before + 1);
		check_word("code_flags",
			{code_bytes[3], code_bytes[2], code_bytes[1], code_bytes[0]}, seen_flags);
		check_word("code_address",
			{code_bytes[7], code_bytes[6], code_bytes[5], code_bytes[4]}, seen_address);
		check_word("code_compare",
			{code_bytes[11], code_bytes[10], code_bytes[9], code_bytes[8]}, seen_compare);
		check_word("code_replace",
			{code_bytes[15], code_bytes[14], code_bytes[13], code_bytes[12]}, seen_replace);
		report_test("cheat record", errors_before);
	endtask

	initial begin
		RESET          = 1'b1;
		ioctl_download = 1'b0;
		ioctl_index    = 8'd0;
		ioctl_wr       = 1'b0;
		ioctl_addr     = '0;
		ioctl_dout     = 8'h00;
		repeat (10) @(posedge clk_sys);
		#1;
		RESET = 1'b0;
		next_cycle();
		test_reset();
		test_sms_download();
		test_gg_flag();
		test_config();
		test_cheat();
		$display("Checks %0d, errors %0d", check_count, error_count);
		result_printed = 1'b1;
		if (error_count == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

	// Run cut short by an assertion
	final begin
		if (!result_printed)
			$display("=== FAIL ===");
	end

endmodule

// ==== verilog/cart_loader.sv ====
//====================================================================
// Cartridge loading unit, top level
// Takes the host download port, sorts bytes by index and hands them
// to the ROM writer, the cheat assembler and the config registers.
// All outside connections are plain ports.
//====================================================================

`timescale 1ns/100ps

module cart_loader #(
	parameter int ROM_ADDR_W = 22
) (
	input  logic                                     clk_sys,
	input  logic                                     RESET,

	// Host download port
	input  logic                                     ioctl_download,
	input  cart_loader_pkg::ioctl_index_t            ioctl_index,
	input  logic                                     ioctl_wr,
	input  logic [cart_loader_pkg::IOCTL_ADDR_W-1:0] ioctl_addr,
	input  logic [7:0]                               ioctl_dout,
	output logic                                     ioctl_wait,

	// External ROM memory
	output logic [ROM_ADDR_W-1:0]                    rom_addr,
	output logic [7:0]                               rom_data,
	output logic                                     rom_req,
	input  logic                                     rom_ack,
	output logic [ROM_ADDR_W-1:0]                    cart_mask,

	// Console configuration
	output logic [7:0]                               sysmode,
	output logic [7:0]                               dsw_f2,
	output logic [7:0]                               dsw_f3,
	output logic [7:0]                               dsw_e0,
	output logic                                     is_gg,
	output logic                                     is_systeme,

	// Cheat record
	output logic [31:0]                              code_flags,
	output logic [31:0]                              code_address,
	output logic [31:0]                              code_compare,
	output logic [31:0]                              code_replace,
	output logic                                     code_valid
);

	load_bus_if load_bus ();

	load_decode load_decode_i (
		.clk_sys        (clk_sys),
		.RESET          (RESET),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.bus            (load_bus.source)
	);

	rom_writer #(.ROM_ADDR_W(ROM_ADDR_W)) rom_writer_i (
		.clk_sys    (clk_sys),
		.RESET      (RESET),
		.bus        (load_bus.sink),
		.rom_addr   (rom_addr),
		.rom_data   (rom_data),
		.rom_req    (rom_req),
		.rom_ack    (rom_ack),
		.ioctl_wait (ioctl_wait),
		.cart_mask  (cart_mask)
	);

	cheat_assembler cheat_assembler_i (
		.clk_sys      (clk_sys),
		.RESET        (RESET),
		.bus          (load_bus.sink),
		.code_flags   (code_flags),
		.code_address (code_address),
		.code_compare (code_compare),
		.code_replace (code_replace),
		.code_valid   (code_valid)
	);

	config_regs config_regs_i (
		.clk_sys    (clk_sys),
		.RESET      (RESET),
		.bus        (load_bus.sink),
		.sysmode    (sysmode),
		.dsw_f2     (dsw_f2),
		.dsw_f3     (dsw_f3),
		.dsw_e0     (dsw_e0),
		.is_gg      (is_gg),
		.is_systeme (is_systeme)
	);

endmodule

// ==== verilog/cart_loader_pkg.sv ====
//====================================================================
// Shared definitions for the cartridge loading unit
// Download index codes, load target encoding and the cheat record
// layout. Modules refer to these by scoped name.
//====================================================================

package cart_loader_pkg;

	// Host download port
	localparam int IOCTL_ADDR_W = 25;

	typedef logic [7:0] ioctl_index_t;

	// Download index codes as sent by the host
	localparam ioctl_index_t IDX_SMS     = 8'd1;
	localparam ioctl_index_t IDX_GG      = 8'd2;
	localparam ioctl_index_t IDX_SYSMODE = 8'd4;
	localparam ioctl_index_t IDX_DSW     = 8'd254;
	localparam ioctl_index_t IDX_CHEAT   = 8'd255;

	// F2, F3 and E0 DIP switch ports of System E
	localparam int DSW_COUNT = 3;

	typedef enum logic [2:0] {
		TGT_NONE,
		TGT_CART,
		TGT_SYSMODE,
		TGT_DSW,
		TGT_CHEAT
	} load_target_e;

	// Byte k of the download lands in bytes[k]; each word is LSB first
	typedef union packed {
		logic [15:0][7:0] bytes;
		struct packed {
			logic [31:0] replace;
			logic [31:0] compare;
			logic [31:0] address;
			logic [31:0] flags;
		} word;
	} cheat_code_u;

endpackage

// ==== verilog/cheat_assembler.sv ====
//====================================================================
// Cheat code assembler
// Collects the 16 bytes of one cheat record and strobes code_valid
// for a single cycle once the last byte is in. The record is read
// out as four 32-bit words.
//====================================================================

`timescale 1ns/100ps

module cheat_assembler (
	input  logic        clk_sys,
	input  logic        RESET,
	load_bus_if.sink    bus,
	output logic [31:0] code_flags,
	output logic [31:0] code_address,
	output logic [31:0] code_compare,
	output logic [31:0] code_replace,
	output logic        code_valid
);

	cart_loader_pkg::cheat_code_u record;
	logic cheat_wr;

	assign cheat_wr = bus.wr && bus.target == cart_loader_pkg::TGT_CHEAT;

	// Low address nibble picks the byte within the record
	always_ff @(posedge clk_sys) begin
		if (cheat_wr)
			record.bytes[bus.addr[3:0]] <= bus.data;
	end

	always_ff @(posedge clk_sys) begin
		if (RESET)
			code_valid <= 1'b0;
		else
			code_valid <= cheat_wr && bus.addr[3:0] == 4'd15;
	end

	//==================================================================
	// Word view of the finished record
	//==================================================================

	assign code_flags   = record.word.flags;
	assign code_address = record.word.address;
	assign code_compare = record.word.compare;
	assign code_replace = record.word.replace;

endmodule

// ==== verilog/config_regs.sv ====
//====================================================================
// Console configuration registers
// System E mode byte, the three DIP switch bytes and the console
// type flags that follow from which index the cart came in on.
//====================================================================

`timescale 1ns/100ps

module config_regs (
	input  logic       clk_sys,
	input  logic       RESET,
	load_bus_if.sink   bus,
	output logic [7:0] sysmode,
	output logic [7:0] dsw_f2,
	output logic [7:0] dsw_f3,
	output logic [7:0] dsw_e0,
	output logic       is_gg,
	output logic       is_systeme
);

	logic [7:0] dsw [cart_loader_pkg::DSW_COUNT];

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			sysmode    <= 8'h00;
			is_gg      <= 1'b0;
			is_systeme <= 1'b0;
			for (int i = 0; i < cart_loader_pkg::DSW_COUNT; i++)
				dsw[i] <= 8'h00;
		end else if (bus.wr) begin
			case (bus.target)
				cart_loader_pkg::TGT_CART: begin
					is_gg      <= bus.gg;
					is_systeme <= 1'b0;
				end
				cart_loader_pkg::TGT_SYSMODE: begin
					sysmode    <= bus.data;
					is_systeme <= 1'b1;
				end
				// Decoder only passes addresses 0 to 2 here
				cart_loader_pkg::TGT_DSW:
					dsw[bus.addr[1:0]] <= bus.data;
				default: ;
			endcase
		end
	end

	assign dsw_f2 = dsw[0];
	assign dsw_f3 = dsw[1];
	assign dsw_e0 = dsw[2];

endmodule

// ==== verilog/load_bus_if.sv ====
//====================================================================
// Classified download byte, from the decoder to the consumers
// The decoder drives the source side, every consumer takes the sink
// side and reacts only to its own target.
//====================================================================

`timescale 1ns/100ps

interface load_bus_if;

	logic                                    wr;
	cart_loader_pkg::load_target_e           target;
	logic [cart_loader_pkg::IOCTL_ADDR_W-1:0] addr;
	logic [7:0]                              data;
	// First cycle of an active cart download
	logic                                    start;
	// Cart came in through the GG index
	logic                                    gg;

	modport source (output wr, target, addr, data, start, gg);

	modport sink (input wr, target, addr, data, start, gg);

endinterface

// ==== verilog/load_decode.sv ====
//====================================================================
// Download decoder
// Registers each host write and tags it with a load target taken
// from the download index. Also makes the cart start pulse.
//====================================================================

`timescale 1ns/100ps

module load_decode (
	input  logic                                     clk_sys,
	input  logic                                     RESET,
	input  logic                                     ioctl_download,
	input  cart_loader_pkg::ioctl_index_t            ioctl_index,
	input  logic                                     ioctl_wr,
	input  logic [cart_loader_pkg::IOCTL_ADDR_W-1:0] ioctl_addr,
	input  logic [7:0]                               ioctl_dout,
	load_bus_if.source                               bus
);

	localparam int ADDR_W = cart_loader_pkg::IOCTL_ADDR_W;

	cart_loader_pkg::load_target_e target;
	logic cart_active;
	logic cart_active_d;

	assign cart_active = ioctl_download &&
		(ioctl_index == cart_loader_pkg::IDX_SMS || ioctl_index == cart_loader_pkg::IDX_GG);

	always_comb begin
		target = cart_loader_pkg::TGT_NONE;
		if (ioctl_download) begin
			case (ioctl_index)
				cart_loader_pkg::IDX_SMS,
				cart_loader_pkg::IDX_GG:
					target = cart_loader_pkg::TGT_CART;
				// Only the first mode byte is meaningful
				cart_loader_pkg::IDX_SYSMODE:
					if (ioctl_addr == '0) target = cart_loader_pkg::TGT_SYSMODE;
				cart_loader_pkg::IDX_DSW:
					if (ioctl_addr < ADDR_W'(cart_loader_pkg::DSW_COUNT))
						target = cart_loader_pkg::TGT_DSW;
				cart_loader_pkg::IDX_CHEAT:
					target = cart_loader_pkg::TGT_CHEAT;
				default:
					target = cart_loader_pkg::TGT_NONE;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			bus.wr        <= 1'b0;
			bus.target    <= cart_loader_pkg::TGT_NONE;
			bus.start     <= 1'b0;
			bus.gg        <= 1'b0;
			cart_active_d <= 1'b0;
		end else begin
			bus.wr        <= ioctl_wr;
			bus.target    <= target;
			bus.gg        <= ioctl_index == cart_loader_pkg::IDX_GG;
			cart_active_d <= cart_active;
			bus.start     <= cart_active && !cart_active_d;
		end
	end

	// Payload follows the strobe
	always_ff @(posedge clk_sys) begin
		bus.addr <= ioctl_addr;
		bus.data <= ioctl_dout;
	end

endmodule

// ==== verilog/rom_writer.sv ====
//====================================================================
// Cartridge ROM writer
// Pushes each cart byte to external memory with a req/ack toggle
// pair and holds the host off with ioctl_wait until the ack comes
// back. Builds the address mask of the loaded image on the way.
//====================================================================

`timescale 1ns/100ps

module rom_writer #(
	parameter int ROM_ADDR_W = 22
) (
	input  logic                  clk_sys,
	input  logic                  RESET,
	load_bus_if.sink              bus,
	output logic [ROM_ADDR_W-1:0] rom_addr,
	output logic [7:0]            rom_data,
	output logic                  rom_req,
	input  logic                  rom_ack,
	output logic                  ioctl_wait,
	output logic [ROM_ADDR_W-1:0] cart_mask
);

	logic cart_wr;
	logic write_done;

	assign cart_wr = bus.wr && bus.target == cart_loader_pkg::TGT_CART;

	// Memory has matched our toggle
	assign write_done = ioctl_wait && rom_req == rom_ack;

	//==================================================================
	// Handshake and address counter
	//==================================================================

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			rom_req    <= 1'b0;
			ioctl_wait <= 1'b0;
			rom_addr   <= '0;
			cart_mask  <= '0;
		end else begin
			if (cart_wr) begin
				rom_req    <= ~rom_req;
				ioctl_wait <= 1'b1;
				// Address 0 starts a new image
				if (bus.addr == '0)
					cart_mask <= '0;
				else
					cart_mask <= cart_mask | bus.addr[ROM_ADDR_W-1:0];
			end else if (write_done) begin
				ioctl_wait <= 1'b0;
			end

			if (bus.start)
				rom_addr <= '0;
			else if (write_done && !cart_wr)
				rom_addr <= rom_addr + ROM_ADDR_W'(1);
		end
	end

	// Data held stable for the whole request
	always_ff @(posedge clk_sys) begin
		if (cart_wr)
			rom_data <= bus.data;
	end

endmodule
